// ==== hdl/tv1_pkg.sv ====
`default_nettype none

package tv1_pkg;

  typedef logic [8:0]  coord_t;     // Raster row or column
  typedef logic [3:0]  color_t;     // Palette index
  typedef logic [6:0]  bgm_addr_t;  // BGM word address
  typedef logic [9:0]  chr_addr_t;
  typedef logic [31:0] olb_word_t;  // Eight packed colour indices, pixel 0 in bits 3:0
  typedef logic [4:0]  tile_idx_t;
  typedef logic [23:0] rgb_t;       // {R, G, B}

  ////////////////////
  // Raster timing

  localparam coord_t NUM_ROWS = 9'd263;
  localparam coord_t NUM_COLS = 9'd260;

  // Render window, overscan included
  localparam coord_t FIRST_ROW_RENDER = 9'd19;
  localparam coord_t LAST_ROW_RENDER  = 9'd250;
  localparam coord_t FIRST_COL_RENDER = 9'd23;
  localparam coord_t LAST_COL_RENDER  = 9'd230;

  // Visible window, 192 x 222
  localparam coord_t FIRST_ROW_VISIBLE = 9'd24;
  localparam coord_t LAST_ROW_VISIBLE  = 9'd245;
  localparam coord_t FIRST_COL_VISIBLE = 9'd24;
  localparam coord_t LAST_COL_VISIBLE  = 9'd215;

  localparam coord_t FIRST_COL_HSYNC = 9'd240;
  localparam coord_t LAST_COL_HSYNC  = 9'd259;
  localparam coord_t FIRST_ROW_VSYNC = 9'd260;
  localparam coord_t LAST_ROW_VSYNC  = 9'd262;

  localparam int FILL_TILES = 32;           // Tiles fetched per line
  localparam color_t BORDER_COLOR = 4'd1;   // Black

  ////////////////////
  // CPU address map, A[12:9]

  localparam logic [3:0] BGM_PAGE = 4'b1000;  // $1000-$11FF
  localparam logic [3:0] REG_PAGE = 4'b1010;  // $1400-$15FF

  // Colour generator
  localparam rgb_t PALETTE [16] = '{
    24'h00009B, 24'h000000, 24'h0000FF, 24'hA100FF,
    24'h00FF00, 24'hA0FF9D, 24'h00FFFF, 24'h00A100,
    24'hFF0000, 24'hFFA100, 24'hFF00FF, 24'hFFA09F,
    24'hFFFF00, 24'hA3A000, 24'hA1A09D, 24'hFFFFFF
  };

endpackage

`default_nettype wire

// ==== hdl/cpu_bus.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_bus (
  input  wire logic               CLK,
  input  wire logic               rst_n,
  input  wire logic [12:0]        A,
  input  wire logic [7:0]         DB_I,
  input  wire logic               RDB,
  input  wire logic               WRB,
  input  wire logic               CSB,
  input  wire tv1_pkg::olb_word_t bgm_rdata,
  output tv1_pkg::bgm_addr_t      bgm_addr,
  output logic [3:0]              bgm_byte_we,
  output logic [7:0]              bgm_wbyte,
  output logic [7:0]              DB_O,
  output logic                    DB_OE,
  output logic [7:0]              ctrl0,      // Bitmap mode, invert bits, sprite bits
  output logic [7:0]              bm_colors,  // {fg, bg}
  output logic [7:0]              bm_window,  // {ymax, xmax}
  output logic [7:0]              ch_colors   // {fg, bg}
);

  logic       rd, wr, sel_bgm, sel_reg;
  logic [7:0] reg_byte, bgm_byte, dbo_q;
  logic [1:0] byte_q;
  logic       bgm_pend;  // BGM read seen last cycle

  assign rd = ~(CSB | RDB);
  assign wr = ~(CSB | WRB);
  assign sel_bgm = (A[12:9] == tv1_pkg::BGM_PAGE);
  assign sel_reg = (A[12:9] == tv1_pkg::REG_PAGE);

  assign bgm_addr = A[8:2];
  assign bgm_wbyte = DB_I;
  assign bgm_byte_we = (sel_bgm & wr) ? (4'b0001 << A[1:0]) : 4'b0000;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ctrl0 <= '0;
      bm_colors <= '0;
      bm_window <= '0;
      ch_colors <= '0;
    end else if (sel_reg & wr) begin
      case (A[1:0])
        2'd0: ctrl0 <= DB_I;
        2'd1: bm_colors <= DB_I;
        2'd2: bm_window <= DB_I;
        2'd3: ch_colors <= DB_I;
      endcase
    end
  end

  always_comb begin
    case (A[1:0])
      2'd0: reg_byte = ctrl0;
      2'd1: reg_byte = bm_colors;
      2'd2: reg_byte = bm_window;
      default: reg_byte = ch_colors;
    endcase
  end

  ////////////////////
  // Read-back

  // BGM data is already a registered memory output, so it goes straight
  // to DB_O for one cycle and is then held in dbo_q
  assign bgm_byte = bgm_rdata[byte_q*8 +: 8];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) bgm_pend <= 1'b0;
    else bgm_pend <= rd & sel_bgm;
  end

  always_ff @(posedge CLK) begin
    if (rd & sel_bgm) byte_q <= A[1:0];
    if (rd & sel_reg) dbo_q <= reg_byte;
    else if (bgm_pend) dbo_q <= bgm_byte;
  end

  assign DB_O = bgm_pend ? bgm_byte : dbo_q;
  assign DB_OE = rd;

  a_no_rdwr : assert property (@(posedge CLK) disable iff (!rst_n) !(rd && wr));

endmodule

`default_nettype wire

// ==== hdl/bg_memory.sv ====
`default_nettype none
`timescale 1ns/1ps

module bg_memory (
  input  wire logic               CLK,
  input  wire tv1_pkg::bgm_addr_t cpu_addr,
  input  wire logic [3:0]         cpu_byte_we,
  input  wire logic [7:0]         cpu_wbyte,
  output tv1_pkg::olb_word_t      cpu_rdata,
  input  wire tv1_pkg::bgm_addr_t render_addr,
  output tv1_pkg::olb_word_t      render_rdata
);

  // 128 words, byte 0 in bits 7:0
  tv1_pkg::olb_word_t mem [128];

  always_ff @(posedge CLK) begin
    for (int i = 0; i < 4; i++) begin
      if (cpu_byte_we[i]) begin
        mem[cpu_addr][i*8 +: 8] <= cpu_wbyte;
      end
    end
  end

  // CPU port
  always_ff @(posedge CLK) begin
    cpu_rdata <= mem[cpu_addr];
  end

  // Render port, free running so the fill never waits on the CPU
  always_ff @(posedge CLK) begin
    render_rdata <= mem[render_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/video_timing.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_timing (
  input  wire logic       CLK,
  input  wire logic       rst_n,
  output tv1_pkg::coord_t row,
  output tv1_pkg::coord_t col,
  output logic            fill_row,
  output logic            render_px,
  output logic            HS,
  output logic            VS,
  output logic            VBL,
  output logic            vis_de
);

  logic render_row, render_col, visible_px;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      row <= '0;
      col <= '0;
    end else if (col == tv1_pkg::NUM_COLS - 9'd1) begin
      col <= '0;
      row <= (row == tv1_pkg::NUM_ROWS - 9'd1) ? 9'd0 : row + 9'd1;
    end else begin
      col <= col + 9'd1;
    end
  end

  // Two rows ahead of the first render row, the last one is already in the buffer
  assign fill_row = (row >= tv1_pkg::FIRST_ROW_RENDER - 9'd2) &&
                    (row <= tv1_pkg::LAST_ROW_RENDER - 9'd1);

  assign render_row = (row >= tv1_pkg::FIRST_ROW_RENDER) && (row <= tv1_pkg::LAST_ROW_RENDER);
  assign render_col = (col >= tv1_pkg::FIRST_COL_RENDER) && (col <= tv1_pkg::LAST_COL_RENDER);
  assign render_px = render_row & render_col;

  assign visible_px = (row >= tv1_pkg::FIRST_ROW_VISIBLE) && (row <= tv1_pkg::LAST_ROW_VISIBLE) &&
                      (col >= tv1_pkg::FIRST_COL_VISIBLE) && (col <= tv1_pkg::LAST_COL_VISIBLE);

  ////////////////////
  // Sync outputs, one cycle behind the counters

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      HS <= 1'b0;
      VS <= 1'b0;
      VBL <= 1'b1;
      vis_de <= 1'b0;
    end else begin
      HS <= (col >= tv1_pkg::FIRST_COL_HSYNC) && (col <= tv1_pkg::LAST_COL_HSYNC);
      VS <= (row >= tv1_pkg::FIRST_ROW_VSYNC) && (row <= tv1_pkg::LAST_ROW_VSYNC);
      VBL <= ~render_row;
      vis_de <= visible_px;
    end
  end

  a_col_range : assert property (@(posedge CLK) disable iff (!rst_n) col < tv1_pkg::NUM_COLS);

endmodule

`default_nettype wire

// ==== hdl/line_fill.sv ====
`default_nettype none
`timescale 1ns/1ps

module line_fill (
  input  wire logic               CLK,
  input  wire logic               rst_n,
  input  wire tv1_pkg::coord_t    row,
  input  wire tv1_pkg::coord_t    col,
  input  wire logic               fill_row,
  input  wire logic [7:0]         ctrl0,
  input  wire logic [7:0]         bm_colors,
  input  wire logic [7:0]         bm_window,
  input  wire logic [7:0]         ch_colors,
  output tv1_pkg::bgm_addr_t      bgm_addr,
  input  wire tv1_pkg::olb_word_t bgm_rdata,
  input  wire tv1_pkg::chr_addr_t ROMINIT_ADDR,
  input  wire logic [7:0]         ROMINIT_DATA,
  input  wire logic               ROMINIT_VALID,
  output tv1_pkg::tile_idx_t      olb_addr,
  output tv1_pkg::olb_word_t      olb_wdata,
  output logic [7:0]              olb_wen,
  output logic [1:0]              olb_wsel   // One-hot row being written
);

  typedef enum logic {FILL_IDLE, FILL_RUN} fill_state_e;

  fill_state_e        state;
  tv1_pkg::tile_idx_t tile_cnt, issue_tx, tx1, tx2;
  logic               start, issue, v1, v2;
  logic [4:0]         ty;
  logic [7:0]         chr [1024];
  logic [7:0]         chr_q, bgm_byte, byte2, pat;
  tv1_pkg::chr_addr_t chr_addr;
  logic [3:0]         lo_nib;
  logic [1:0]         hi_pair;
  logic               ch_win;
  tv1_pkg::color_t    fg, bg;

  assign ty = row[7:3];
  assign start = fill_row && (col == 9'd0);
  assign issue = start || (state == FILL_RUN);
  assign issue_tx = start ? 5'd0 : tile_cnt;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= FILL_IDLE;
      tile_cnt <= '0;
    end else if (start) begin
      state <= FILL_RUN;
      tile_cnt <= 5'd1;
    end else if (state == FILL_RUN) begin
      if (tile_cnt == tv1_pkg::tile_idx_t'(tv1_pkg::FILL_TILES - 1)) state <= FILL_IDLE;
      tile_cnt <= tile_cnt + 5'd1;
    end
  end

  ////////////////////
  // Stage 1, BGM word address

  assign bgm_addr = {ty[4:1], issue_tx[4:2]};

  // Stage 2, BGM byte picks the character pattern
  assign bgm_byte = bgm_rdata[tx1[1:0]*8 +: 8];
  assign chr_addr = {bgm_byte[6:0], row[2:0]};

  always_ff @(posedge CLK) begin
    if (ROMINIT_VALID) chr[ROMINIT_ADDR] <= ROMINIT_DATA;
    chr_q <= chr[chr_addr];
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= issue;
      v2 <= v1;
    end
  end

  always_ff @(posedge CLK) begin
    tx1 <= issue_tx;
    tx2 <= tx1;
    byte2 <= bgm_byte;
  end

  ////////////////////
  // Stage 3, layer select and colour expansion

  assign ch_win = ((tx2[4:1] < bm_window[3:0]) ^ ctrl0[6]) &
                  ((ty[4:1] < bm_window[7:4]) ^ ctrl0[7]);
  assign lo_nib = byte2[{~row[3], 2'b00} +: 4];
  assign hi_pair = byte2[{~row[3:2], 1'b0} +: 2];

  always_comb begin
    bg = bm_colors[3:0];
    fg = bm_colors[7:4];
    pat = 8'h00;
    if (ch_win) begin
      bg = ch_colors[3:0];
      fg = ch_colors[7:4];
      pat = ty[0] ? 8'h00 : chr_q;  // Odd tile rows are blank
    end else if (ctrl0[0]) begin
      if (ctrl0[1]) begin
        if (lo_nib != 4'd0) begin   // Zero nibble shows the background
          pat = 8'hFF;
          fg = lo_nib;
        end
      end else begin
        pat = {{4{hi_pair[1]}}, {4{hi_pair[0]}}};
      end
    end
    // MSB of the pattern is the leftmost pixel
    for (int i = 0; i < 8; i++) begin
      olb_wdata[i*4 +: 4] = pat[7-i] ? fg : bg;
    end
  end

  assign olb_addr = tx2;
  assign olb_wen = {8{v2}};
  assign olb_wsel = {v2 & ~row[0], v2 & row[0]};

endmodule

`default_nettype wire

// ==== hdl/line_row.sv ====
`default_nettype none
`timescale 1ns/1ps

module line_row (
  input  wire logic               CLK,
  input  wire logic               write_sel,
  input  wire tv1_pkg::tile_idx_t addr,
  input  wire tv1_pkg::olb_word_t wdata,
  input  wire logic [7:0]         wen,    // One bit per pixel nibble
  output tv1_pkg::olb_word_t      rdata
);

  // 32 words of eight pixels, 256 pixels per row
  tv1_pkg::olb_word_t mem [32];

  always_ff @(posedge CLK) begin
    rdata <= mem[addr];
    for (int i = 0; i < 8; i++) begin
      if (wen[i]) begin
        mem[addr][i*4 +: 4] <= wdata[i*4 +: 4];
      end
    end
  end

  a_wen_sel : assert property (@(posedge CLK) !write_sel |-> (wen == 8'h00));

endmodule

`default_nettype wire

// ==== hdl/pixel_out.sv ====
`default_nettype none
`timescale 1ns/1ps

module pixel_out (
  input  wire logic               CLK,
  input  wire logic               rst_n,
  input  wire tv1_pkg::coord_t    row,
  input  wire tv1_pkg::coord_t    col,
  input  wire logic               render_px,
  input  wire logic               vis_de,     // Already one cycle late
  input  wire tv1_pkg::olb_word_t row0_rdata,
  input  wire tv1_pkg::olb_word_t row1_rdata,
  output tv1_pkg::tile_idx_t      rd_addr,
  output logic                    DE,
  output tv1_pkg::rgb_t           RGB
);

  logic               sel_q, render_q;
  logic [2:0]         nib_q;
  tv1_pkg::olb_word_t word;
  tv1_pkg::color_t    color_q;

  assign rd_addr = col[7:3];

  // Row data arrives a cycle after the address, so its select is delayed too
  assign word = sel_q ? row1_rdata : row0_rdata;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= 1'b0;
      nib_q <= '0;
      render_q <= 1'b0;
      color_q <= tv1_pkg::BORDER_COLOR;
      DE <= 1'b0;
    end else begin
      sel_q <= row[0];
      nib_q <= col[2:0];
      render_q <= render_px;
      color_q <= render_q ? word[nib_q*4 +: 4] : tv1_pkg::BORDER_COLOR;
      DE <= vis_de;  // Lines up with RGB
    end
  end

  assign RGB = tv1_pkg::PALETTE[color_q];

endmodule

`default_nettype wire

// ==== hdl/epochtv1.sv ====
`default_nettype none
`timescale 1ns/1ps

module epochtv1 (
  input  wire logic              CLK,
  input  wire logic              rst_n,
  // CHR ROM load
  input  wire tv1_pkg::chr_addr_t ROMINIT_ADDR,
  input  wire logic [7:0]        ROMINIT_DATA,
  input  wire logic              ROMINIT_VALID,
  // CPU bus
  input  wire logic [12:0]       A,
  input  wire logic [7:0]        DB_I,
  input  wire logic              RDB,
  input  wire logic              WRB,
  input  wire logic              CSB,
  output logic [7:0]             DB_O,
  output logic                   DB_OE,
  // Video
  output logic                   VBL,
  output logic                   DE,
  output logic                   HS,
  output logic                   VS,
  output tv1_pkg::rgb_t          RGB
);

  tv1_pkg::coord_t    row, col;
  logic               fill_row, render_px, vis_de;
  logic [7:0]         ctrl0, bm_colors, bm_window, ch_colors;
  tv1_pkg::bgm_addr_t cpu_bgm_addr, fill_bgm_addr;
  logic [3:0]         bgm_byte_we;
  logic [7:0]         bgm_wbyte;
  tv1_pkg::olb_word_t cpu_bgm_rdata, fill_bgm_rdata;
  tv1_pkg::tile_idx_t olb_addr, rd_addr;
  tv1_pkg::olb_word_t olb_wdata;
  logic [7:0]         olb_wen;
  logic [1:0]         olb_wsel;
  tv1_pkg::olb_word_t row_rdata [2];

  cpu_bus u_cpu_bus (
    .CLK(CLK), .rst_n(rst_n), .A(A), .DB_I(DB_I), .RDB(RDB), .WRB(WRB), .CSB(CSB),
    .bgm_rdata(cpu_bgm_rdata), .bgm_addr(cpu_bgm_addr), .bgm_byte_we(bgm_byte_we),
    .bgm_wbyte(bgm_wbyte), .DB_O(DB_O), .DB_OE(DB_OE),
    .ctrl0(ctrl0), .bm_colors(bm_colors), .bm_window(bm_window), .ch_colors(ch_colors)
  );

  bg_memory u_bg_memory (
    .CLK(CLK), .cpu_addr(cpu_bgm_addr), .cpu_byte_we(bgm_byte_we), .cpu_wbyte(bgm_wbyte),
    .cpu_rdata(cpu_bgm_rdata), .render_addr(fill_bgm_addr), .render_rdata(fill_bgm_rdata)
  );

  video_timing u_video_timing (
    .CLK(CLK), .rst_n(rst_n), .row(row), .col(col), .fill_row(fill_row),
    .render_px(render_px), .HS(HS), .VS(VS), .VBL(VBL), .vis_de(vis_de)
  );

  line_fill u_line_fill (
    .CLK(CLK), .rst_n(rst_n), .row(row), .col(col), .fill_row(fill_row),
    .ctrl0(ctrl0), .bm_colors(bm_colors), .bm_window(bm_window), .ch_colors(ch_colors),
    .bgm_addr(fill_bgm_addr), .bgm_rdata(fill_bgm_rdata),
    .ROMINIT_ADDR(ROMINIT_ADDR), .ROMINIT_DATA(ROMINIT_DATA), .ROMINIT_VALID(ROMINIT_VALID),
    .olb_addr(olb_addr), .olb_wdata(olb_wdata), .olb_wen(olb_wen), .olb_wsel(olb_wsel)
  );

  // Ping-pong rows, the one being filled takes the fill address
  for (genvar g = 0; g < 2; g++) begin : g_olb_row
    line_row u_line_row (
      .CLK(CLK), .write_sel(olb_wsel[g]), .addr(olb_wsel[g] ? olb_addr : rd_addr),
      .wdata(olb_wdata), .wen(olb_wen & {8{olb_wsel[g]}}), .rdata(row_rdata[g])
    );
  end

  pixel_out u_pixel_out (
    .CLK(CLK), .rst_n(rst_n), .row(row), .col(col), .render_px(render_px), .vis_de(vis_de),
    .row0_rdata(row_rdata[0]), .row1_rdata(row_rdata[1]), .rd_addr(rd_addr),
    .DE(DE), .RGB(RGB)
  );

endmodule

`default_nettype wire

// ==== include/tv1_model.svh ====
`ifndef TV1_MODEL_SVH
`define TV1_MODEL_SVH

// Colour index of the pixel shown at raster row r, column c
// regs[0] bit 1 set selects the 4-bit (low-res) bitmap mode
function automatic tv1_pkg::color_t model_pixel(input logic [7:0] chr [1024],
                                                input logic [31:0] bgm [128],
                                                input logic [7:0] regs [4],
                                                input int r, input int c);
  tv1_pkg::coord_t s;
  logic [4:0]      tx, ty;
  logic [7:0]      b, pat;
  logic [3:0]      nib;
  logic [1:0]      hi;
  int              off;
  if (r < tv1_pkg::FIRST_ROW_RENDER || r > tv1_pkg::LAST_ROW_RENDER ||
      c < tv1_pkg::FIRST_COL_RENDER || c > tv1_pkg::LAST_COL_RENDER) begin
    return tv1_pkg::BORDER_COLOR;
  end
  s = tv1_pkg::coord_t'(r - 1);  // Line buffer holds the previous row
  tx = c[7:3];
  ty = s[7:3];
  b = bgm[{ty[4:1], tx[4:2]}][tx[1:0]*8 +: 8];
  if (((tx[4:1] < regs[2][3:0]) ^ regs[0][6]) && ((ty[4:1] < regs[2][7:4]) ^ regs[0][7])) begin
    pat = ty[0] ? 8'h00 : chr[{b[6:0], s[2:0]}];
    return pat[7 - (c % 8)] ? regs[3][7:4] : regs[3][3:0];
  end
  if (!regs[0][0]) return regs[1][3:0];
  if (regs[0][1]) begin
    nib = s[3] ? b[3:0] : b[7:4];
    return (nib != 4'd0) ? nib : regs[1][3:0];
  end
  off = 2 * (3 - int'(s[3:2]));
  hi = b[off +: 2];
  return (((c % 8) < 4) ? hi[1] : hi[0]) ? regs[1][7:4] : regs[1][3:0];
endfunction

function automatic tv1_pkg::rgb_t model_rgb(input tv1_pkg::color_t idx);
  return tv1_pkg::PALETTE[idx];
endfunction

`endif

// ==== testbench/tb_epochtv1.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_epochtv1;

  logic               CLK;
  logic               rst_n;
  tv1_pkg::chr_addr_t ROMINIT_ADDR;
  logic [7:0]         ROMINIT_DATA;
  logic               ROMINIT_VALID;
  logic [12:0]        A;
  logic [7:0]         DB_I;
  logic               RDB, WRB, CSB;
  logic [7:0]         DB_O;
  logic               DB_OE, VBL, DE, HS, VS;
  tv1_pkg::rgb_t      RGB;

  // Shadow state for the model
  logic [7:0]  chr_sh [1024];
  logic [31:0] bgm_sh [128];
  logic [7:0]  reg_sh [4];

  int            m_row, m_col, h1_row, h1_col, h2_row, h2_col, cnt;
  bit            rgb_on;
  logic          exp_hs, exp_vs, exp_vbl, exp_de;
  tv1_pkg::rgb_t exp_rgb;

  `include "tv1_model.svh"

  epochtv1 dut (
    .CLK(CLK), .rst_n(rst_n),
    .ROMINIT_ADDR(ROMINIT_ADDR), .ROMINIT_DATA(ROMINIT_DATA), .ROMINIT_VALID(ROMINIT_VALID),
    .A(A), .DB_I(DB_I), .RDB(RDB), .WRB(WRB), .CSB(CSB), .DB_O(DB_O), .DB_OE(DB_OE),
    .VBL(VBL), .DE(DE), .HS(HS), .VS(VS), .RGB(RGB)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////
  // Helpers

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  task automatic load_chr();
    for (int i = 0; i < 1024; i++) begin
      ROMINIT_ADDR = tv1_pkg::chr_addr_t'(i);
      ROMINIT_DATA = rand_byte();
      ROMINIT_VALID = 1'b1;
      chr_sh[i] = ROMINIT_DATA;
      @(posedge CLK);
      #1;
    end
    ROMINIT_VALID = 1'b0;
  endtask

  task automatic write_bgm(input logic [6:0] w, input logic [1:0] b, input logic [7:0] v);
    A = {tv1_pkg::BGM_PAGE, w, b};
    DB_I = v;
    CSB = 1'b0;
    WRB = 1'b0;
    @(posedge CLK);  // Write lands on this edge
    #1;
    CSB = 1'b1;
    WRB = 1'b1;
    bgm_sh[w][b*8 +: 8] = v;
  endtask

  task automatic write_reg(input logic [1:0] idx, input logic [7:0] v);
    A = {tv1_pkg::REG_PAGE, 7'd0, idx};
    DB_I = v;
    CSB = 1'b0;
    WRB = 1'b0;
    @(posedge CLK);
    #1;
    CSB = 1'b1;
    WRB = 1'b1;
    reg_sh[idx] = v;
  endtask

  // One-cycle read and then the byte must appear and stay put
  task automatic read_check(input logic [12:0] addr, input logic [7:0] exp, input string name);
    A = addr;
    CSB = 1'b0;
    RDB = 1'b0;
    @(posedge CLK);
    #1;
    CSB = 1'b1;
    RDB = 1'b1;
    @(negedge CLK);
    assert (DB_O == exp) else fail_value(name, exp, DB_O);
    @(negedge CLK);
    assert (DB_O == exp) else fail_value({name, " hold"}, exp, DB_O);
    @(posedge CLK);
    #1;
  endtask

  task automatic wait_raster(input int r, input int c);
    int n;
    n = 0;
    while (!(m_row == r && m_col == c) &&
           n < int'(tv1_pkg::NUM_ROWS) * int'(tv1_pkg::NUM_COLS) + 8) begin
      @(posedge CLK);
      #1;
      n++;
    end
    assert (m_row == r && m_col == c) else fail_plain("Timed out waiting for raster position");
  endtask

  // From the first row after rendering to the same row of the next frame
  task automatic run_frame();
    @(posedge CLK);
    #1;
    wait_raster(int'(tv1_pkg::LAST_ROW_RENDER) + 1, 0);
  endtask

  // Mode 0 is character only, 1 is low-res bitmap and 2 is high-res bitmap
  task automatic apply_setting(input int mode);
    logic [7:0] c0;
    c0 = rand_byte();
    c0[1:0] = (mode == 0) ? 2'b00 : ((mode == 1) ? 2'b11 : 2'b01);
    write_reg(2'd0, c0);
    write_reg(2'd1, rand_byte());
    write_reg(2'd2, rand_byte());
    write_reg(2'd3, rand_byte());
  endtask

  ////////////////////
  // Raster position counted from reset

  always @(posedge CLK) begin
    if (!rst_n) begin
      m_row <= 0;
      m_col <= 0;
      h1_row <= 0;
      h1_col <= 0;
      h2_row <= 0;
      h2_col <= 0;
      cnt <= 0;
    end else begin
      h2_row <= h1_row;
      h2_col <= h1_col;
      h1_row <= m_row;
      h1_col <= m_col;
      if (cnt < 3) cnt <= cnt + 1;
      if (m_col == int'(tv1_pkg::NUM_COLS) - 1) begin
        m_col <= 0;
        m_row <= (m_row == int'(tv1_pkg::NUM_ROWS) - 1) ? 0 : m_row + 1;
      end else begin
        m_col <= m_col + 1;
      end
    end
  end

  // Outputs are checked mid-cycle
  always @(negedge CLK) begin
    if (rst_n && cnt >= 1) begin
      assert (DB_OE == (!CSB && !RDB)) else fail_value("db_oe", !CSB && !RDB, DB_OE);
      exp_hs = (h1_col >= tv1_pkg::FIRST_COL_HSYNC) && (h1_col <= tv1_pkg::LAST_COL_HSYNC);
      exp_vs = (h1_row >= tv1_pkg::FIRST_ROW_VSYNC) && (h1_row <= tv1_pkg::LAST_ROW_VSYNC);
      exp_vbl = (h1_row < tv1_pkg::FIRST_ROW_RENDER) || (h1_row > tv1_pkg::LAST_ROW_RENDER);
      assert (HS == exp_hs) else fail_value("hsync", exp_hs, HS);
      assert (VS == exp_vs) else fail_value("vsync", exp_vs, VS);
      assert (VBL == exp_vbl) else fail_value("vblank", exp_vbl, VBL);
      if (cnt >= 2) begin
        exp_de = (h2_row >= tv1_pkg::FIRST_ROW_VISIBLE) && (h2_row <= tv1_pkg::LAST_ROW_VISIBLE) &&
                 (h2_col >= tv1_pkg::FIRST_COL_VISIBLE) && (h2_col <= tv1_pkg::LAST_COL_VISIBLE);
        assert (DE == exp_de) else fail_value("de", exp_de, DE);
        if (rgb_on) begin
          exp_rgb = model_rgb(model_pixel(chr_sh, bgm_sh, reg_sh, h2_row, h2_col));
          assert (RGB == exp_rgb)
            else fail_value($sformatf("rgb row %0d col %0d", h2_row, h2_col), exp_rgb, RGB);
        end
      end
    end
  end

  ////////////////////
  // Stimulus

  initial begin
    logic [6:0] w;
    logic [1:0] b;
    logic [7:0] v;
    void'($urandom(32'h1676));
    rst_n = 1'b0;
    CSB = 1'b1;
    RDB = 1'b1;
    WRB = 1'b1;
    A = '0;
    DB_I = '0;
    ROMINIT_ADDR = '0;
    ROMINIT_DATA = '0;
    ROMINIT_VALID = 1'b0;
    rgb_on = 1'b0;
    repeat (16) @(posedge CLK);
    #1;
    rst_n = 1'b1;

    load_chr();
    for (int i = 0; i < 512; i++) begin
      write_bgm(i[8:2], i[1:0], rand_byte());
    end

    for (int k = 0; k < 4; k++) begin
      write_reg(k[1:0], rand_byte());
      read_check({tv1_pkg::REG_PAGE, 7'd0, k[1:0]}, reg_sh[k], "reg readback");
    end

    // Single byte write with the whole word read back
    repeat (8) begin
      v = rand_byte();
      w = v[6:0];
      v = rand_byte();
      b = v[1:0];
      v = rand_byte();
      write_bgm(w, b, v);
      for (int k = 0; k < 4; k++) begin
        read_check({tv1_pkg::BGM_PAGE, w, k[1:0]}, bgm_sh[w][k*8 +: 8], "bgm readback");
      end
    end

    // Register changes only in vertical blank
    wait_raster(int'(tv1_pkg::LAST_ROW_RENDER) + 1, 0);
    for (int k = 0; k < 6; k++) begin
      apply_setting(k % 3);
      rgb_on = 1'b1;
      run_frame();
      run_frame();
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== epochtv1.f ====
+incdir+include
hdl/tv1_pkg.sv
hdl/cpu_bus.sv
hdl/bg_memory.sv
hdl/video_timing.sv
hdl/line_fill.sv
hdl/line_row.sv
hdl/pixel_out.sv
hdl/epochtv1.sv
testbench/tb_epochtv1.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_epochtv1 -f epochtv1.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "Simulation OK"
else
  echo "Simulation FAILED"
  exit 1
fi
